// File: hw/iomem_cfg.svh
`ifndef IOMEM_CFG_SVH
`define IOMEM_CFG_SVH

// Bus geometry of the I/O memory port
`define IOMEM_AW 32  // Address width in bits
`define IOMEM_DW 32  // Data width in bits, four byte lanes

// Top address byte that selects the GPIO register
`define GPIO_REGION 8'h02

`define LED_W         8   // Number of board LEDs
`define LED_SHIFT_MAX 10  // Upper bound of the LED shift amount
`define LED_SHIFT_W   5   // Width of the shift amount counter

// Internal reset stays low this many cycles after the external one releases
`define RESET_STRETCH 16

`endif

// File: hw/iomem_pkg.sv
package iomem_pkg;

	// Decoded view of an I/O address
	typedef struct packed {
		logic [7:0]  region;  // Selects the peripheral
		logic [23:0] offset;  // Address inside the selected peripheral
	} iomem_addr_fields_t;

	// The same address word seen raw or split into region and offset
	typedef union packed {
		logic [31:0]        raw;     // Word as it arrives from the bus
		iomem_addr_fields_t fields;  // Region and offset split
	} iomem_addr_u;

endpackage

// File: hw/iomem_if.sv
`timescale 1ns/100ps
`include "iomem_cfg.svh"

// Valid/ready I/O bus
// A request holds until a single-cycle ready answers it
interface iomem_if;
	logic                    valid;  // Request pending, payload stable
	logic                    ready;  // One-cycle answer from the slave
	logic [`IOMEM_DW/8-1:0]  wstrb;  // Byte lane write enables, zero for a read
	logic [`IOMEM_AW-1:0]    addr;   // Byte address of the access
	logic [`IOMEM_DW-1:0]    wdata;  // Write data, lanes picked by wstrb
	logic [`IOMEM_DW-1:0]    rdata;  // Value from before the access

	modport host (
		output valid,
		output wstrb,
		output addr,
		output wdata,
		input  ready,
		input  rdata
	);

	modport periph (
		input  valid,
		input  wstrb,
		input  addr,
		input  wdata,
		output ready,
		output rdata
	);
endinterface

// File: hw/por_stretch.sv
`timescale 1ns/100ps
`include "iomem_cfg.svh"

// Holds the core in reset for a fixed stretch after the board reset lets go
module por_stretch (
	input  logic clk,
	input  logic resetn,
	output logic core_resetn
);
	localparam int CNT_W = $clog2(`RESET_STRETCH + 1);  // Must hold the final count itself

	logic [CNT_W-1:0] stretch_cnt;   // Cycles seen with resetn high
	logic             stretch_done;  // Counter has saturated

	assign stretch_done = (stretch_cnt == CNT_W'(`RESET_STRETCH));  // Saturation point
	assign core_resetn  = stretch_done;  // Core leaves reset only once the count is full

	always_ff @(posedge clk) begin
		if (!resetn) begin
			stretch_cnt <= '0;  // Every low sample restarts the stretch
		end else if (!stretch_done) begin
			stretch_cnt <= stretch_cnt + CNT_W'(1);  // Count up and stop at the limit
		end
	end

	// A glitch on the board reset must always reach the core
	ext_reset_reaches_core: assert property (@(posedge clk) !resetn |=> !core_resetn)
		else $error("por_stretch: core_resetn high after resetn was sampled low");
endmodule

// File: hw/iomem_decoder.sv
`timescale 1ns/100ps
`include "iomem_cfg.svh"

// Splits the I/O bus by the top address byte
// Unmapped regions get a zero answer so the CPU never stalls on them
module iomem_decoder (
	input  logic    clk,
	input  logic    core_resetn,
	iomem_if.periph host,
	iomem_if.host   gpio
);
	iomem_pkg::iomem_addr_u host_addr;  // Host address in both views

	logic gpio_sel;     // Address falls in the GPIO region
	logic unmap_ready;  // Answer of the local responder for unmapped regions

	always_comb begin
		host_addr.raw = host.addr;  // Load the raw word and read it back split
	end

	assign gpio_sel = (host_addr.fields.region == `GPIO_REGION);

	// Routing toward the GPIO block is purely combinational
	// A request that follows an unmapped answer waits one cycle so that ready
	// never shows up on the host side two cycles in a row
	assign gpio.valid = host.valid && gpio_sel && !unmap_ready;
	assign gpio.wstrb = host.wstrb;                                 // Strobes pass unchanged
	assign gpio.addr  = `IOMEM_AW'(host_addr.fields.offset);        // Region byte stripped
	assign gpio.wdata = host.wdata;

	// Local responder for every region without a peripheral
	// It stores nothing, a write there is simply dropped
	always_ff @(posedge clk) begin
		if (!core_resetn) begin
			unmap_ready <= 1'b0;
		end else begin
			unmap_ready <= host.valid && !gpio_sel && !host.ready;  // Skip while any ready is up
		end
	end

	// Only one slave answers at a time so the OR is a clean merge
	assign host.ready = gpio.ready | unmap_ready;
	assign host.rdata = gpio.ready ? gpio.rdata : '0;  // Unmapped reads return zero

	// The GPIO block and the local responder must never answer together
	single_responder: assert property (@(posedge clk) disable iff (!core_resetn)
		!(gpio.ready && unmap_ready))
		else $error("iomem_decoder: GPIO and unmapped responder answered together");

	// Each answer toward the host is a single-cycle pulse
	host_ready_pulse: assert property (@(posedge clk) disable iff (!core_resetn)
		host.ready |=> !host.ready)
		else $error("iomem_decoder: host ready high two cycles in a row");
endmodule

// File: hw/gpio_led.sv
`timescale 1ns/100ps
`include "iomem_cfg.svh"

// 32-bit GPIO register with byte strobes
// The LEDs show its low bits shifted right by a self-advancing amount
module gpio_led (
	input  logic              clk,
	input  logic              core_resetn,
	iomem_if.periph           bus,
	output logic [`LED_W-1:0] leds
);
	localparam int LANES = `IOMEM_DW / 8;  // Byte lanes in one data word

	logic [`IOMEM_DW-1:0]    gpio_reg;   // The register itself
	logic [`IOMEM_DW-1:0]    gpio_shr;   // Register after the LED shift
	logic [`LED_SHIFT_W-1:0] shift_amt;  // Current right shift of the LED view
	logic                    serve;      // A new request is taken this cycle
	logic                    all_lit;    // Every LED is on

	// The register mirrors across its whole region since the offset is not decoded
	assign serve = bus.valid && !bus.ready;  // Own ready blocks a second service

	assign gpio_shr = gpio_reg >> shift_amt;
	assign leds     = gpio_shr[`LED_W-1:0];
	assign all_lit  = &leds;

	// Control state and the register, both cleared by the core reset
	always_ff @(posedge clk) begin
		if (!core_resetn) begin
			bus.ready <= 1'b0;
			gpio_reg  <= '0;
			shift_amt <= '0;
		end else begin
			bus.ready <= serve;  // Answer exactly one cycle after the request
			if (serve) begin
				for (int lane = 0; lane < LANES; lane++) begin
					if (bus.wstrb[lane]) begin
						gpio_reg[8*lane +: 8] <= bus.wdata[8*lane +: 8];  // Only strobed lanes change
					end
				end
			end
			// Shift keeps moving while the lights are all on, up to the limit
			if (all_lit && shift_amt < `LED_SHIFT_W'(`LED_SHIFT_MAX)) begin
				shift_amt <= shift_amt + `LED_SHIFT_W'(1);
			end
		end
	end

	// Captures the register for the answer of the request being served
	always_ff @(posedge clk) begin
		if (serve) begin
			bus.rdata <= gpio_reg;  // Value from before this access lands with ready
		end
	end

	// Amount saturates at the limit even with the register changing under it
	shift_limit: assert property (@(posedge clk) disable iff (!core_resetn)
		shift_amt <= `LED_SHIFT_W'(`LED_SHIFT_MAX))
		else $error("gpio_led: shift amount %0d beyond limit", shift_amt);

	// A held request is answered once and only once
	gpio_ready_pulse: assert property (@(posedge clk) disable iff (!core_resetn)
		bus.ready |=> !bus.ready)
		else $error("gpio_led: ready high two cycles in a row");
endmodule

// File: hw/soc_io_top.sv
`timescale 1ns/100ps
`include "iomem_cfg.svh"

// I/O corner of the board top
// The CPU side enters on plain ports and fans out through the decoder
module soc_io_top (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   iomem_valid,
	input  logic [`IOMEM_DW/8-1:0] iomem_wstrb,
	input  logic [`IOMEM_AW-1:0]   iomem_addr,
	input  logic [`IOMEM_DW-1:0]   iomem_wdata,
	output logic                   iomem_ready,
	output logic [`IOMEM_DW-1:0]   iomem_rdata,
	output logic [`LED_W-1:0]      leds
);
	logic core_resetn;  // Stretched reset for all bus logic

	iomem_if bus_host ();  // CPU side of the decoder
	iomem_if bus_gpio ();  // Decoder to the GPIO register

	// Plain ports onto the host bus
	assign bus_host.valid = iomem_valid;
	assign bus_host.wstrb = iomem_wstrb;
	assign bus_host.addr  = iomem_addr;
	assign bus_host.wdata = iomem_wdata;
	assign iomem_ready    = bus_host.ready;
	assign iomem_rdata    = bus_host.rdata;

	por_stretch u_por_stretch (
		.clk         (clk),
		.resetn      (resetn),
		.core_resetn (core_resetn)
	);

	iomem_decoder u_iomem_decoder (
		.clk         (clk),
		.core_resetn (core_resetn),
		.host        (bus_host.periph),
		.gpio        (bus_gpio.host)
	);

	gpio_led u_gpio_led (
		.clk         (clk),
		.core_resetn (core_resetn),
		.bus         (bus_gpio.periph),
		.leds        (leds)
	);
endmodule

// File: test/tb_soc_io_tests.svh
// First request goes out while the core is still in its reset stretch
task automatic test_reset_state();
	logic [`IOMEM_DW-1:0] rd;
	int                   waited;
	begin_test("reset_state");
	bus_access(make_addr(`GPIO_REGION, 24'($urandom)), '0, '0, rd, waited);
	if (waited < `RESET_STRETCH) begin
		errors++;
		$display("%s: ready came after %0d cycles, before the reset stretch ended",
			test_name, waited);
	end
	check_value('0, rd);
	check_value('0, 32'(leds));
	end_test();
endtask

// Read the GPIO register and compare data and lights with the model
task automatic gpio_read_check();
	logic [`IOMEM_DW-1:0] rd;
	int                   waited;
	bus_access(make_addr(`GPIO_REGION, 24'($urandom)), '0, '0, rd, waited);
	check_value(model_reg, rd);
	check_value(32'(led_view(model_reg, model_amt)), 32'(leds));
endtask

task automatic test_byte_writes();
	logic [`IOMEM_DW-1:0]   rd;
	logic [`IOMEM_DW-1:0]   data;
	logic [`IOMEM_DW/8-1:0] strb;
	int                     waited;
	begin_test("byte_writes");
	for (int n = 0; n < 20; n++) begin
		strb       = 4'($urandom);
		data       = $urandom;
		data[7:0]  = 8'($urandom % 255);  // Low byte never all ones, the LEDs stay unshifted
		bus_access(make_addr(`GPIO_REGION, 24'($urandom)), strb, data, rd, waited);
		check_value(model_reg, rd);  // Old value comes back
		model_reg = merge_bytes(model_reg, data, strb);
		gpio_read_check();
	end
	end_test();
endtask

task automatic test_old_value();
	logic [`IOMEM_DW-1:0] rd;
	logic [`IOMEM_DW-1:0] data;
	int                   waited;
	begin_test("old_value");
	data      = $urandom;
	data[7:0] = 8'h5a;
	bus_access(make_addr(`GPIO_REGION, 24'h0), 4'hf, data, rd, waited);
	check_value(model_reg, rd);
	model_reg = data;
	gpio_read_check();  // New value now visible
	end_test();
endtask

// Unmapped regions answer zero and store nothing
task automatic test_unmapped();
	logic [`IOMEM_DW-1:0] rd;
	logic [7:0]           region;
	int                   waited;
	begin_test("unmapped");
	for (int n = 0; n < 6; n++) begin
		region = 8'($urandom);
		if (region == `GPIO_REGION) begin
			region = region + 8'd1;
		end
		bus_access(make_addr(region, 24'($urandom)), 4'($urandom), $urandom, rd, waited);
		check_value('0, rd);
		gpio_read_check();  // GPIO register must be untouched
	end
	end_test();
endtask

// Fails if any bus timing assertion fired during the tests before it
task automatic test_ready_timing();
	begin_test("one_cycle_ready");
	if (assert_fails != 0) begin
		errors++;
		$display("%s: %0d bus timing assertion failures", test_name, assert_fails);
	end
	end_test();
endtask

// Last, since only a reset brings the shift amount back to zero
task automatic test_led_shift();
	logic [`IOMEM_DW-1:0] rd;
	logic [`IOMEM_DW-1:0] data;
	int                   waited;
	begin_test("led_shift");
	data      = $urandom;
	data[7:0] = 8'hff;  // All lights on starts the shift
	bus_access(make_addr(`GPIO_REGION, 24'($urandom)), 4'hf, data, rd, waited);
	check_value(model_reg, rd);
	model_reg = data;
	model_amt = settle_shift(model_reg, model_amt);
	repeat (`LED_SHIFT_MAX + 4) @(negedge clk);  // Enough cycles to reach any stop point
	check_value(32'(led_view(model_reg, model_amt)), 32'(leds));
	data            = $urandom;
	data[model_amt] = 1'b0;  // Lights not all on at the frozen amount
	bus_access(make_addr(`GPIO_REGION, 24'($urandom)), 4'hf, data, rd, waited);
	check_value(model_reg, rd);
	model_reg = data;
	repeat (4) @(negedge clk);
	gpio_read_check();  // Amount held over the write
	end_test();
endtask

task automatic run_tests();
	test_reset_state();
	test_byte_writes();
	test_old_value();
	test_unmapped();
	test_ready_timing();
	test_led_shift();
endtask

// File: test/tb_soc_io.sv
`timescale 1ns/100ps
`include "iomem_cfg.svh"

// Testbench for the I/O corner of the board top, stands in for the CPU on the I/O bus
module tb_soc_io;
	logic                   clk;
	logic                   resetn;
	logic                   iomem_valid;
	logic [`IOMEM_DW/8-1:0] iomem_wstrb;
	logic [`IOMEM_AW-1:0]   iomem_addr;
	logic [`IOMEM_DW-1:0]   iomem_wdata;
	logic                   iomem_ready;
	logic [`IOMEM_DW-1:0]   iomem_rdata;
	logic [`LED_W-1:0]      leds;

	int    errors;         // Failed checks of every kind
	int    assert_fails;   // Failures seen by the bus timing assertions
	int    tests_run;
	int    tests_failed;
	int    test_err_base;  // Error count when the current test began
	string test_name;      // Shown in every error line

	logic [`IOMEM_DW-1:0] model_reg;  // Expected GPIO register
	int                   model_amt;  // Expected LED shift amount

	soc_io_top UUT (
		.clk         (clk),
		.resetn      (resetn),
		.iomem_valid (iomem_valid),
		.iomem_wstrb (iomem_wstrb),
		.iomem_addr  (iomem_addr),
		.iomem_wdata (iomem_wdata),
		.iomem_ready (iomem_ready),
		.iomem_rdata (iomem_rdata),
		.leds        (leds)
	);

	always #2 clk = ~clk;  // 4 ns period

	// Ready follows a request sampled with the core out of reset by exactly one cycle
	ready_after_valid: assert property (@(posedge clk) disable iff (!resetn)
		(UUT.core_resetn && iomem_valid && !iomem_ready) |=> iomem_ready)
		else begin
			errors++;
			assert_fails++;
			$display("Ready did not arrive one cycle after valid at %0t", $time);
		end

	ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		iomem_ready |=> !iomem_ready)
		else begin
			errors++;
			assert_fails++;
			$display("Ready stayed high longer than one cycle at %0t", $time);
		end

	ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
		iomem_ready |-> $past(iomem_valid))
		else begin
			errors++;
			assert_fails++;
			$display("Ready came without a pending request at %0t", $time);
		end

	// Nothing answers while the core is still held in reset
	quiet_in_reset: assert property (@(posedge clk) !UUT.core_resetn |-> !iomem_ready)
		else begin
			errors++;
			assert_fails++;
			$display("Ready rose during the reset stretch at %0t", $time);
		end

	function automatic logic [`IOMEM_AW-1:0] make_addr(input logic [7:0] region,
		input logic [23:0] offset);
		iomem_pkg::iomem_addr_u a;  // Built from its fields, sent raw
		a.fields.region = region;
		a.fields.offset = offset;
		return a.raw;
	endfunction

	// Byte lanes picked by the strobe take the new data
	function automatic logic [`IOMEM_DW-1:0] merge_bytes(input logic [`IOMEM_DW-1:0] old_val,
		input logic [`IOMEM_DW-1:0] new_val, input logic [`IOMEM_DW/8-1:0] strb);
		logic [`IOMEM_DW-1:0] res;
		res = old_val;
		for (int i = 0; i < `IOMEM_DW / 8; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [`LED_W-1:0] led_view(input logic [`IOMEM_DW-1:0] reg_val,
		input int amt);
		logic [`IOMEM_DW-1:0] shifted;
		shifted = reg_val >> amt;
		return shifted[`LED_W-1:0];
	endfunction

	// Amount climbs while all lights are on, until the limit
	function automatic int settle_shift(input logic [`IOMEM_DW-1:0] reg_val, input int amt);
		int a;
		a = amt;
		while (a < `LED_SHIFT_MAX && &(led_view(reg_val, a))) begin
			a++;
		end
		return a;
	endfunction

	task automatic check_value(input logic [`IOMEM_DW-1:0] exp, input logic [`IOMEM_DW-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_err_base) begin
			$display("Test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d failed checks", test_name, errors - test_err_base);
		end
	endtask

	// One request held until ready, dropped on the falling edge that sees ready
	task automatic bus_access(input logic [`IOMEM_AW-1:0] addr,
		input logic [`IOMEM_DW/8-1:0] strb, input logic [`IOMEM_DW-1:0] data,
		output logic [`IOMEM_DW-1:0] rdata, output int waited);
		bit answered;
		answered = 1'b0;
		waited   = 0;
		rdata    = '0;
		@(negedge clk);
		iomem_valid = 1'b1;
		iomem_addr  = addr;
		iomem_wstrb = strb;
		iomem_wdata = data;
		while (!answered && waited < `RESET_STRETCH + 8) begin
			@(negedge clk);
			waited++;
			if (iomem_ready) begin
				answered = 1'b1;
				rdata    = iomem_rdata;  // Stable here, between the two rising edges
			end
		end
		iomem_valid = 1'b0;
		iomem_wstrb = '0;
		if (!answered) begin
			errors++;
			$display("%s: no ready within %0d cycles for address %h", test_name, waited, addr);
		end
	endtask

	`include "tb_soc_io_tests.svh"

	initial begin
		clk          = 1'b0;
		resetn       = 1'b0;
		iomem_valid  = 1'b0;
		iomem_wstrb  = '0;
		iomem_addr   = '0;
		iomem_wdata  = '0;
		errors       = 0;
		assert_fails = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_reg    = '0;
		model_amt    = 0;
		test_name    = "reset";
		void'($urandom(32'h2260e781));
		repeat (5) @(negedge clk);  // Five rising edges with resetn low
		resetn = 1'b1;
		run_tests();
		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end
endmodule

// File: filelist.f
+incdir+hw
+incdir+test
hw/iomem_pkg.sv
hw/iomem_if.sv
hw/por_stretch.sv
hw/iomem_decoder.sv
hw/gpio_led.sv
hw/soc_io_top.sv
test/tb_soc_io.sv
